/* vlog.f */
+incdir+include
verilog/db_edge_pkg.sv
verilog/db_quad_edge.sv
verilog/db_edge_map.sv
verilog/db_pu_edge.sv
tests/tb_db_pu_edge.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the PU edge map testbench.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
	-f vlog.f \
	--top-module tb_db_pu_edge \
	--Mdir obj_dir -o tb_db_pu_edge \
	&& ./obj_dir/tb_db_pu_edge > sim.log 2>&1 \
	|| echo "build or simulation ended with an error"

[ -f sim.log ] && cat sim.log

grep -q "^Regression passed$" sim.log 2>/dev/null \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }

/* include/db_edge_model.svh */
/* PU edge map model: expected LCU edge map, walked through the CU quadtree
   in z-order with the plain mid-edge rule at every level */
`ifndef DB_EDGE_MODEL_SVH
`define DB_EDGE_MODEL_SVH

// {ver, hor} cuts of one CU where a split CU is cut both ways
function automatic logic [1:0] cu_cuts(input db_edge_pkg::pu_mode_t mode,
		input logic split);
	logic [1:0] cuts;
	if (split) begin
		cuts = 2'b11;
	end else begin
		case (mode)
			db_edge_pkg::PU_2NXN: cuts = 2'b01;
			db_edge_pkg::PU_NX2N: cuts = 2'b10;
			db_edge_pkg::PU_NXN:  cuts = 2'b11;
			default:              cuts = 2'b00;   // 2Nx2N
		endcase
	end
	return cuts;
endfunction

// marks the mid-edges of one CU given in 4-pixel units
function automatic db_edge_pkg::lcu_edge_s mark_mid_edges(input db_edge_pkg::lcu_edge_s map,
		input int x0, input int y0, input int size, input logic [1:0] cuts);
	db_edge_pkg::lcu_edge_s res;
	int edge_x;
	int edge_y;
	res    = map;
	edge_x = (x0 + size / 2) / 2 - 1;   // 8-pixel edge index
	edge_y = (y0 + size / 2) / 2 - 1;
	for (int i = 0; i < size; i++) begin
		if (cuts[1]) begin
			res.ver[y0 + i][edge_x] = 1'b1;
		end
		if (cuts[0]) begin
			res.hor[edge_y][x0 + i] = 1'b1;
		end
	end
	return res;
endfunction

function automatic db_edge_pkg::lcu_edge_s expected_map(input db_edge_pkg::cu_split_t split,
		input db_edge_pkg::pu_mode_vec_t mode);
	db_edge_pkg::lcu_edge_s map;
	int n;
	int m;
	int qx;
	int qy;
	map = '0;
	map = mark_mid_edges(map, 0, 0, db_edge_pkg::LCU_ROWS, cu_cuts(mode[1:0], split[0]));
	if (split[0]) begin
		for (int q = 0; q < db_edge_pkg::NUM_QUADS; q++) begin
			n   = db_edge_pkg::CU_QUAD_BASE + q;
			qx  = db_edge_pkg::QUAD_ROWS * (q % 2);
			qy  = db_edge_pkg::QUAD_ROWS * (q / 2);
			map = mark_mid_edges(map, qx, qy, db_edge_pkg::QUAD_ROWS,
				cu_cuts(mode[2*n +: 2], split[n]));
			if (split[n]) begin
				for (int i = 0; i < db_edge_pkg::CU16_PER_QUAD; i++) begin
					m   = db_edge_pkg::CU16_BASE + db_edge_pkg::CU16_PER_QUAD * q + i;
					map = mark_mid_edges(map, qx + db_edge_pkg::CU16_ROWS * (i % 2),
						qy + db_edge_pkg::CU16_ROWS * (i / 2), db_edge_pkg::CU16_ROWS,
						cu_cuts(mode[2*m +: 2], split[m]));
				end
			end
		end
	end
	return map;
endfunction

`endif

/* tests/tb_db_pu_edge.sv */
/* tb_db_pu_edge: directed and random tests of the LCU PU edge map against
   the quadtree reference model */
module tb_db_pu_edge;
	import db_edge_pkg::*;

	`include "db_edge_model.svh"

	localparam int MAP_W     = $bits(lcu_edge_s);
	localparam int NUM_LOADS = 1 + 4 + 20 + 80 + 200;        // reset, unsplit, quads, cu16, random
	localparam int TIMEOUT   = (20 * NUM_LOADS + 50) * 10;

	logic         clk = 1'b0;
	logic         reset_i;
	logic         load_i;
	cu_split_t    cu_split_i;
	pu_mode_vec_t pu_mode_i;
	lcu_edge_s    edge_o;
	logic         edge_valid_o;
	integer       seed = 97;

	db_pu_edge dut0 (
		.clk          (clk),
		.reset_i      (reset_i),
		.load_i       (load_i),
		.cu_split_i   (cu_split_i),
		.pu_mode_i    (pu_mode_i),
		.edge_o       (edge_o),
		.edge_valid_o (edge_valid_o)
	);

	always #5 clk = ~clk;

	// ------------------------------------------------------------------
	// checks and stimulus
	// ------------------------------------------------------------------
	task automatic check_value(input logic [MAP_W-1:0] actual, input logic [MAP_W-1:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
			$display("Regression failed");
			$fatal(1, "check failed");
		end
	endtask

	// one load, result one cycle later, then held with valid low
	task automatic load_and_check(input cu_split_t split, input pu_mode_vec_t mode,
			input string what);
		lcu_edge_s expected;
		expected = expected_map(split, mode);
		@(negedge clk);
		cu_split_i = split;
		pu_mode_i  = mode;
		load_i     = 1'b1;
		@(negedge clk);
		load_i = 1'b0;
		check_value(MAP_W'(edge_valid_o), MAP_W'(1), {what, " valid"});
		check_value(edge_o, expected, {what, " map"});
		@(negedge clk);
		check_value(MAP_W'(edge_valid_o), MAP_W'(0), {what, " valid drop"});
		check_value(edge_o, expected, {what, " hold"});
	endtask

	task automatic verify_reset_state();
		@(negedge clk);
		check_value(MAP_W'(edge_valid_o), MAP_W'(0), "valid after reset");
		check_value(edge_o, '0, "map after reset");
	endtask

	// finer flags and modes all set, so an unsplit LCU must clear them
	task automatic sweep_lcu_modes();
		cu_split_t    split;
		pu_mode_vec_t mode;
		for (int md = 0; md < 4; md++) begin
			split    = '1;
			split[0] = 1'b0;
			mode     = '1;
			mode[MODE_W-1:0] = pu_mode_t'(md);
			load_and_check(split, mode, $sformatf("unsplit LCU mode %0d", md));
		end
	endtask

	// each quadrant unsplit in every mode, then fully split to 8x8
	task automatic sweep_quadrants();
		cu_split_t    split;
		pu_mode_vec_t mode;
		for (int q = 0; q < NUM_QUADS; q++) begin
			for (int md = 0; md < 4; md++) begin
				mode = '0;
				mode[MODE_W*(CU_QUAD_BASE+q) +: MODE_W] = pu_mode_t'(md);
				mode[MODE_W*(CU16_BASE + CU16_PER_QUAD*q) +: MODE_W*CU16_PER_QUAD] = '1;
				split = cu_split_t'(1);
				split[CU16_BASE + CU16_PER_QUAD*q +: CU16_PER_QUAD] = '1;  // hidden by quad
				load_and_check(split, mode, $sformatf("quad %0d mode %0d", q, md));
			end
			split = cu_split_t'(1);
			split[CU_QUAD_BASE+q] = 1'b1;
			split[CU16_BASE + CU16_PER_QUAD*q +: CU16_PER_QUAD] = '1;
			load_and_check(split, '0, $sformatf("quad %0d all 8x8", q));
		end
	endtask

	task automatic sweep_cu16_positions();
		cu_split_t    split;
		pu_mode_vec_t mode;
		int           m;
		for (int q = 0; q < NUM_QUADS; q++) begin
			for (int i = 0; i < CU16_PER_QUAD; i++) begin
				m     = CU16_BASE + CU16_PER_QUAD*q + i;    // z-order index of the 16x16 CU
				split = cu_split_t'(1);
				split[CU_QUAD_BASE+q] = 1'b1;
				for (int md = 0; md < 4; md++) begin
					mode = '0;
					mode[MODE_W*m +: MODE_W] = pu_mode_t'(md);
					load_and_check(split, mode, $sformatf("cu16 %0d mode %0d", m, md));
				end
				split[m] = 1'b1;
				load_and_check(split, '0, $sformatf("cu16 %0d split", m));
			end
		end
	endtask

	// back-to-back loads with each map checked one cycle later
	task automatic random_burst(input int count);
		lcu_edge_s    exp_q[$];
		lcu_edge_s    expected;
		cu_split_t    split;
		pu_mode_vec_t mode;
		for (int i = 0; i < count; i++) begin
			@(negedge clk);
			if (i > 0) begin
				expected = exp_q.pop_front();
				check_value(MAP_W'(edge_valid_o), MAP_W'(1), $sformatf("random %0d valid", i-1));
				check_value(edge_o, expected, $sformatf("random %0d map", i-1));
			end
			split      = cu_split_t'($random(seed));
			mode       = pu_mode_vec_t'({$random(seed), $random(seed)});
			cu_split_i = split;
			pu_mode_i  = mode;
			load_i     = 1'b1;
			exp_q.push_back(expected_map(split, mode));
		end
		@(negedge clk);
		load_i   = 1'b0;
		expected = exp_q.pop_front();
		check_value(MAP_W'(edge_valid_o), MAP_W'(1), "random last valid");
		check_value(edge_o, expected, "random last map");
		repeat (3) begin
			@(negedge clk);
			cu_split_i = cu_split_t'($random(seed));       // inputs move, map must not
			check_value(MAP_W'(edge_valid_o), MAP_W'(0), "valid while idle");
			check_value(edge_o, expected, "map hold while idle");
		end
	endtask

	// ------------------------------------------------------------------
	// main sequence and watchdog
	// ------------------------------------------------------------------
	initial begin
		reset_i    = 1'b1;
		load_i     = 1'b0;
		cu_split_i = '0;
		pu_mode_i  = '0;
		repeat (2) @(negedge clk);
		reset_i = 1'b0;
		verify_reset_state();
		sweep_lcu_modes();
		sweep_quadrants();
		sweep_cu16_positions();
		random_burst(200);
		$display("Regression passed");
		$finish;
	end

	initial begin
		#(TIMEOUT);
		$display("Watchdog: the tests did not finish in the expected time");
		$display("Regression failed");
		$fatal(1, "timeout");
	end

endmodule

/* verilog/db_pu_edge.sv */
/* db_pu_edge: PU edge map of one 64x64 luma LCU for the deblocking filter,
   from the CU quadtree split flags and PU partition modes */
module db_pu_edge (
	input  logic                      clk,
	input  logic                      reset_i,
	input  logic                      load_i,
	input  db_edge_pkg::cu_split_t    cu_split_i,
	input  db_edge_pkg::pu_mode_vec_t pu_mode_i,
	output db_edge_pkg::lcu_edge_s    edge_o,
	output logic                      edge_valid_o
);
	import db_edge_pkg::*;

	quad_cfg_s  quad_cfg  [NUM_QUADS];
	quad_edge_s quad_edge [NUM_QUADS];

	// quadrant q owns 32x32 CU q and 16x16 CUs 4q..4q+3
	for (genvar q = 0; q < NUM_QUADS; q++) begin : gen_cfg
		assign quad_cfg[q].split      = cu_split_i[CU_QUAD_BASE + q];
		assign quad_cfg[q].mode       = pu_mode_i[MODE_W*(CU_QUAD_BASE + q) +: MODE_W];
		assign quad_cfg[q].cu16_split =
			cu_split_i[CU16_BASE + CU16_PER_QUAD*q +: CU16_PER_QUAD];
		assign quad_cfg[q].cu16_mode  =
			pu_mode_i[MODE_W*(CU16_BASE + CU16_PER_QUAD*q) +: MODE_W*CU16_PER_QUAD];
	end

	db_quad_edge quad0 (.cfg_i(quad_cfg[0]), .edge_o(quad_edge[0]));  // top left
	db_quad_edge quad1 (.cfg_i(quad_cfg[1]), .edge_o(quad_edge[1]));  // top right
	db_quad_edge quad2 (.cfg_i(quad_cfg[2]), .edge_o(quad_edge[2]));  // bottom left
	db_quad_edge quad3 (.cfg_i(quad_cfg[3]), .edge_o(quad_edge[3]));  // bottom right

	db_edge_map map0 (
		.clk          (clk),
		.reset_i      (reset_i),
		.load_i       (load_i),
		.lcu_split_i  (cu_split_i[0]),
		.lcu_mode_i   (pu_mode_i[MODE_W-1:0]),
		.quad_i       (quad_edge),
		.edge_o       (edge_o),
		.edge_valid_o (edge_valid_o)
	);

endmodule

/* verilog/db_edge_map.sv */
/* db_edge_map: adds the 64x64 level, places the four quadrant maps into the
   LCU edge map and holds the result for one LCU */
module db_edge_map (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    load_i,
	input  logic                    lcu_split_i,
	input  db_edge_pkg::pu_mode_t   lcu_mode_i,
	input  db_edge_pkg::quad_edge_s quad_i [db_edge_pkg::NUM_QUADS],
	output db_edge_pkg::lcu_edge_s  edge_o,
	output logic                    edge_valid_o
);
	import db_edge_pkg::*;

	logic      lcu_ver;     // x = 32 edge
	logic      lcu_hor;     // y = 32 edge
	lcu_edge_s map_next;    // map of the current inputs

	// ------------------------------------------------------------------
	// 64x64 level
	// ------------------------------------------------------------------
	assign lcu_ver = lcu_split_i | lcu_mode_i[MODE_VER_BIT];
	assign lcu_hor = lcu_split_i | lcu_mode_i[MODE_HOR_BIT];

	// ------------------------------------------------------------------
	// LCU map
	// ------------------------------------------------------------------
	always_comb begin
		map_next = '0;

		for (int r = 0; r < LCU_ROWS; r++) begin
			map_next.ver[r][LCU_MID_EDGE] = lcu_ver;
		end
		map_next.hor[LCU_MID_EDGE] = {LCU_ROWS{lcu_hor}};

		// quadrant edges only exist inside a split LCU
		if (lcu_split_i) begin
			for (int q = 0; q < NUM_QUADS; q++) begin
				// vertical edges take rows by q/2 and edge columns by q%2
				for (int r = 0; r < QUAD_ROWS; r++) begin
					for (int k = 0; k < QUAD_EDGES; k++) begin
						map_next.ver[QUAD_ROWS*(q/2) + r][(LCU_MID_EDGE+1)*(q%2) + k] =
							quad_i[q].ver[r][k];
					end
				end

				// horizontal edges take edge rows by q/2 and columns by q%2
				for (int k = 0; k < QUAD_EDGES; k++) begin
					for (int c = 0; c < QUAD_ROWS; c++) begin
						map_next.hor[(LCU_MID_EDGE+1)*(q/2) + k][QUAD_ROWS*(q%2) + c] =
							quad_i[q].hor[k][c];
					end
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// LCU register
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset_i) begin
			edge_o       <= '0;
			edge_valid_o <= 1'b0;
		end else begin
			edge_valid_o <= load_i;                  // one-cycle pulse per load
			if (load_i) begin
				edge_o <= map_next;
			end
		end
	end

endmodule

/* verilog/db_quad_edge.sv */
/* db_quad_edge: PU edge decisions inside one 32x32 quadrant and its four
   16x16 CUs, all in quadrant-local coordinates */
module db_quad_edge (
	input  db_edge_pkg::quad_cfg_s  cfg_i,
	output db_edge_pkg::quad_edge_s edge_o
);
	import db_edge_pkg::*;

	logic                     mid_ver;   // local x = 16
	logic                     mid_hor;   // local y = 16
	logic [CU16_PER_QUAD-1:0] sub_ver;   // 8-pixel vertical edge of each 16x16 CU
	logic [CU16_PER_QUAD-1:0] sub_hor;   // 8-pixel horizontal edge of each 16x16 CU

	// ------------------------------------------------------------------
	// 32x32 level
	// ------------------------------------------------------------------
	always_comb begin
		if (cfg_i.split) begin
			mid_ver = 1'b1;                          // four 16x16 CUs
			mid_hor = 1'b1;
		end else begin
			mid_ver = cfg_i.mode[MODE_VER_BIT];      // Nx2N or NxN
			mid_hor = cfg_i.mode[MODE_HOR_BIT];      // 2NxN or NxN
		end
	end

	// ------------------------------------------------------------------
	// 16x16 level
	// ------------------------------------------------------------------
	// an unsplit quadrant has no finer edges at all, and a 16x16 CU with
	// its flag set is four 8x8 CUs, which cuts it both ways
	always_comb begin
		for (int i = 0; i < CU16_PER_QUAD; i++) begin
			if (!cfg_i.split) begin
				sub_ver[i] = 1'b0;
				sub_hor[i] = 1'b0;
			end else if (cfg_i.cu16_split[i]) begin
				sub_ver[i] = 1'b1;                   // 8x8 CUs
				sub_hor[i] = 1'b1;
			end else begin
				sub_ver[i] = cfg_i.cu16_mode[i][MODE_VER_BIT];
				sub_hor[i] = cfg_i.cu16_mode[i][MODE_HOR_BIT];
			end
		end
	end

	// ------------------------------------------------------------------
	// placement into the local map
	// ------------------------------------------------------------------
	always_comb begin
		edge_o = '0;

		// 16-pixel edges span the whole quadrant
		for (int r = 0; r < QUAD_ROWS; r++) begin
			edge_o.ver[r][QUAD_MID_EDGE] = mid_ver;
		end
		edge_o.hor[QUAD_MID_EDGE] = {QUAD_ROWS{mid_hor}};

		// CU i sits at column i%2, row i/2 of the 2x2 z-order grid
		for (int i = 0; i < CU16_PER_QUAD; i++) begin
			for (int j = 0; j < CU16_ROWS; j++) begin
				edge_o.ver[CU16_ROWS*(i/2) + j][(QUAD_MID_EDGE+1)*(i%2)] = sub_ver[i];
				edge_o.hor[(QUAD_MID_EDGE+1)*(i/2)][CU16_ROWS*(i%2) + j] = sub_hor[i];
			end
		end
	end

endmodule

/* verilog/db_edge_pkg.sv */
/* db_edge_pkg: geometry, PU mode codes and edge map types for the
   prediction-unit edge map of one 64x64 luma LCU */
package db_edge_pkg;

	// ------------------------------------------------------------------
	// LCU geometry in 4-pixel rows or columns and 8-pixel edge positions
	// ------------------------------------------------------------------
	localparam int LCU_ROWS      = 16;  // 4-pixel rows or columns per LCU
	localparam int LCU_EDGES     = 7;   // internal edges at 8..56
	localparam int LCU_MID_EDGE  = 3;   // the 32-pixel edge
	localparam int QUAD_ROWS     = 8;   // 4-pixel rows per 32x32 quadrant
	localparam int QUAD_EDGES    = 3;   // local 8, 16, 24
	localparam int QUAD_MID_EDGE = 1;   // local 16-pixel edge
	localparam int CU16_ROWS     = 4;   // 4-pixel rows per 16x16 CU
	localparam int NUM_QUADS     = 4;
	localparam int CU16_PER_QUAD = 4;

	// quadtree flag layout in z-order throughout
	localparam int NUM_CUS      = 21;   // 1 + 4 + 16
	localparam int CU_QUAD_BASE = 1;    // first 32x32 CU
	localparam int CU16_BASE    = 5;    // first 16x16 CU

	// ------------------------------------------------------------------
	// PU partition modes
	// ------------------------------------------------------------------
	localparam int MODE_W = 2;

	typedef logic [MODE_W-1:0] pu_mode_t;

	localparam pu_mode_t PU_2NX2N = 2'd0;
	localparam pu_mode_t PU_2NXN  = 2'd1;  // horizontal cut
	localparam pu_mode_t PU_NX2N  = 2'd2;  // vertical cut
	localparam pu_mode_t PU_NXN   = 2'd3;  // both

	localparam int MODE_VER_BIT = 1;
	localparam int MODE_HOR_BIT = 0;

	// ------------------------------------------------------------------
	// input vectors
	// ------------------------------------------------------------------
	typedef logic [NUM_CUS-1:0]        cu_split_t;     // bit 0 is the LCU
	typedef logic [MODE_W*NUM_CUS-1:0] pu_mode_vec_t;  // two bits per CU

	typedef struct packed {
		logic                            split;
		pu_mode_t                        mode;
		logic [CU16_PER_QUAD-1:0]        cu16_split;
		pu_mode_t [CU16_PER_QUAD-1:0]    cu16_mode;
	} quad_cfg_s;

	// ------------------------------------------------------------------
	// edge maps
	// ------------------------------------------------------------------
	typedef logic [QUAD_EDGES-1:0] quad_row_t;   // vertical edges of a quadrant row
	typedef logic [QUAD_ROWS-1:0]  quad_col_t;   // one horizontal edge of a quadrant
	typedef logic [LCU_EDGES-1:0]  edge_row_t;   // bit k is the edge at x = 8(k+1)
	typedef logic [LCU_ROWS-1:0]   edge_col_t;   // bit c is 4-pixel column c

	typedef struct packed {
		quad_row_t [QUAD_ROWS-1:0]  ver;
		quad_col_t [QUAD_EDGES-1:0] hor;
	} quad_edge_s;

	typedef struct packed {
		edge_row_t [LCU_ROWS-1:0]  ver;          // index is the 4-pixel row
		edge_col_t [LCU_EDGES-1:0] hor;          // index k is the edge at y = 8(k+1)
	} lcu_edge_s;

endpackage
